//--- include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// base opcodes, instr[6:0]
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_SYSTEM    7'b1110011

// funct12 values under SYSTEM with funct3 == 0
`define RV_SYS_ECALL    12'h000
`define RV_SYS_MRET     12'h302

// machine-mode csr addresses
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MEPC     12'h341
`define RV_CSR_MCAUSE   12'h342

`define RV_CAUSE_ECALL_M 32'd11 // environment call from M-mode

`define RV_RESET_PC     32'h0000_0000

`endif

//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, viewed per format
    typedef union packed {
        r_fmt_t      r;
        i_fmt_t      i;
        s_fmt_t      s;
        b_fmt_t      b;
        u_fmt_t      u;
        j_fmt_t      j;
        logic [31:0] raw;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       a_sel;   // 0 rs1, 1 pc
        logic [1:0] b_sel;   // rs2, imm, csr, zero
        logic [1:0] wb_sel;  // alu, pc+4, load, csr old
        logic       rd_we;
        logic [2:0] br_type; // funct3 coding, 3'b010 = none
        logic       jump;
        logic       mem_re;
        logic       mem_we;
        logic       csr_we;
        logic       csr_set;
        logic       ecall;
        logic       mret;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        re;
        logic        we;
    } dmem_req_t;

endpackage

`default_nettype wire

//--- hdl/rv_decode.sv
`default_nettype none

`include "rv_consts.svh"

module rv_decode (
    input  rv_pkg::instr_u instr,
    output rv_pkg::ctrl_t  ctrl,
    output logic [31:0]    imm
);

    localparam logic [2:0] BR_NONE = 3'b010; // funct3 not used by any branch

    localparam logic [1:0] B_RS2  = 2'd0;
    localparam logic [1:0] B_IMM  = 2'd1;
    localparam logic [1:0] B_ZERO = 2'd3;

    localparam logic [1:0] WB_PC4  = 2'd1;
    localparam logic [1:0] WB_LOAD = 2'd2;
    localparam logic [1:0] WB_CSR  = 2'd3;

    // shared by OP and OP-IMM; alt picks SUB / SRA
    function automatic rv_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  return rv_pkg::ALU_SLL;
            3'b010:  return rv_pkg::ALU_SLT;
            3'b011:  return rv_pkg::ALU_SLTU;
            3'b100:  return rv_pkg::ALU_XOR;
            3'b101:  return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  return rv_pkg::ALU_OR;
            default: return rv_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        case (instr.r.opcode)
            `RV_OP_LUI, `RV_OP_AUIPC:
                imm = {instr.u.imm, 12'b0};
            `RV_OP_JAL:
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            `RV_OP_BRANCH:
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            `RV_OP_STORE:
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            `RV_OP_JALR, `RV_OP_LOAD, `RV_OP_IMM, `RV_OP_SYSTEM:
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            default:
                imm = 32'h0;
        endcase
    end

    always_comb begin
        ctrl         = '0; // unknown opcode ends up here, no writes
        ctrl.alu_op  = rv_pkg::ALU_ADD;
        ctrl.br_type = BR_NONE;
        case (instr.r.opcode)
            `RV_OP_LUI: begin
                ctrl.b_sel  = B_IMM;
                ctrl.alu_op = rv_pkg::ALU_PASS_B;
                ctrl.rd_we  = 1'b1;
            end
            `RV_OP_AUIPC: begin
                ctrl.a_sel = 1'b1;
                ctrl.b_sel = B_IMM;
                ctrl.rd_we = 1'b1;
            end
            `RV_OP_JAL, `RV_OP_JALR: begin
                ctrl.a_sel  = (instr.r.opcode == `RV_OP_JAL); // jalr is rs1 relative
                ctrl.b_sel  = B_IMM;
                ctrl.wb_sel = WB_PC4;
                ctrl.rd_we  = 1'b1;
                ctrl.jump   = 1'b1;
            end
            `RV_OP_BRANCH: begin
                ctrl.a_sel = 1'b1; // target = pc + imm
                ctrl.b_sel = B_IMM;
                if (instr.b.funct3[2:1] != 2'b01)
                    ctrl.br_type = instr.b.funct3;
            end
            `RV_OP_LOAD: begin
                ctrl.b_sel = B_IMM;
                if (instr.i.funct3 == 3'b010) begin // LW only
                    ctrl.wb_sel = WB_LOAD;
                    ctrl.mem_re = 1'b1;
                    ctrl.rd_we  = 1'b1;
                end
            end
            `RV_OP_STORE: begin
                ctrl.b_sel  = B_IMM;
                ctrl.mem_we = (instr.s.funct3 == 3'b010);
            end
            `RV_OP_IMM: begin
                ctrl.b_sel  = B_IMM;
                ctrl.alu_op = alu_from_f3(instr.i.funct3,
                                          (instr.i.funct3 == 3'b101) & instr.r.funct7[5]);
                ctrl.rd_we  = 1'b1;
            end
            `RV_OP_REG: begin
                ctrl.b_sel  = B_RS2;
                ctrl.alu_op = alu_from_f3(instr.r.funct3, instr.r.funct7[5]);
                ctrl.rd_we  = 1'b1;
            end
            `RV_OP_SYSTEM: begin
                case (instr.i.funct3)
                    3'b001: begin // csrrw, alu passes rs1
                        ctrl.b_sel  = B_ZERO;
                        ctrl.alu_op = rv_pkg::ALU_OR;
                        ctrl.wb_sel = WB_CSR;
                        ctrl.rd_we  = 1'b1;
                        ctrl.csr_we = 1'b1;
                    end
                    3'b010: begin // csrrs, csr unit ors rs1 in
                        ctrl.b_sel   = B_ZERO;
                        ctrl.alu_op  = rv_pkg::ALU_OR;
                        ctrl.wb_sel  = WB_CSR;
                        ctrl.rd_we   = 1'b1;
                        ctrl.csr_we  = 1'b1;
                        ctrl.csr_set = 1'b1;
                    end
                    3'b000: begin
                        ctrl.ecall = (instr.i.imm == `RV_SYS_ECALL);
                        ctrl.mret  = (instr.i.imm == `RV_SYS_MRET);
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic        clk,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_data,
    input  logic        we,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32]; // regs[0] is never written

    always_ff @(posedge clk) begin
        if (we && rd_addr != 5'd0)
            regs[rd_addr] <= rd_data;
    end

    assign rs1_data = (rs1_addr == 5'd0) ? 32'h0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? 32'h0 : regs[rs2_addr];

endmodule

`default_nettype wire

//--- hdl/rv_alu.sv
`default_nettype none

module rv_alu (
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    input  rv_pkg::alu_op_e op,
    input  logic [31:0]     rs1_data,
    input  logic [31:0]     rs2_data,
    input  logic [2:0]      br_type,
    output logic [31:0]     result,
    output logic            br_taken
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = a - b;
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:   result = {31'b0, a < b};
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = 32'h0;
        endcase
    end

    // branch compare works on the register values, not the alu operands
    always_comb begin
        case (br_type)
            3'b000:  br_taken = (rs1_data == rs2_data);
            3'b001:  br_taken = (rs1_data != rs2_data);
            3'b100:  br_taken = ($signed(rs1_data) <  $signed(rs2_data));
            3'b101:  br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  br_taken = (rs1_data <  rs2_data);
            3'b111:  br_taken = (rs1_data >= rs2_data);
            default: br_taken = 1'b0; // no branch
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/rv_csr.sv
`default_nettype none

`include "rv_consts.svh"

module rv_csr (
    input  logic           clk,
    input  logic           arst_n,
    input  rv_pkg::instr_u instr,
    input  rv_pkg::ctrl_t  ctrl,
    input  logic [31:0]    pc,
    input  logic [31:0]    wdata,
    output logic [31:0]    csr_rdata,
    output logic [31:0]    trap_pc
);

    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [11:0] addr;
    logic [31:0] new_val;

    assign addr = instr.i.imm;

    always_comb begin
        case (addr)
            `RV_CSR_MTVEC:  csr_rdata = mtvec;
            `RV_CSR_MEPC:   csr_rdata = mepc;
            `RV_CSR_MCAUSE: csr_rdata = mcause;
            default:        csr_rdata = 32'h0; // unimplemented csr
        endcase
    end

    assign new_val = ctrl.csr_set ? (csr_rdata | wdata) : wdata;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtvec  <= 32'h0;
            mepc   <= 32'h0;
            mcause <= 32'h0;
        end else if (ctrl.ecall) begin
            mepc   <= pc;
            mcause <= `RV_CAUSE_ECALL_M;
        end else if (ctrl.csr_we) begin
            case (addr)
                `RV_CSR_MTVEC:  mtvec  <= new_val;
                `RV_CSR_MEPC:   mepc   <= new_val;
                `RV_CSR_MCAUSE: mcause <= new_val;
                default: ;
            endcase
        end
    end

    // direct mode only, mode bits of mtvec ignored
    assign trap_pc = ctrl.mret ? mepc : {mtvec[31:2], 2'b00};

endmodule

`default_nettype wire

//--- hdl/rv_core.sv
`default_nettype none

`include "rv_consts.svh"

module rv_core (
    input  logic              clk,
    input  logic              arst_n,
    output logic [31:0]       imem_addr,
    input  logic [31:0]       imem_rdata,
    output rv_pkg::dmem_req_t dmem_req,
    input  logic [31:0]       dmem_rdata,
    output logic [31:0]       pc
);

    rv_pkg::instr_u instr;
    rv_pkg::ctrl_t  ctrl;
    logic [31:0]    imm;
    logic [31:0]    rs1_data, rs2_data;
    logic [31:0]    alu_a, alu_b, alu_result;
    logic           br_taken;
    logic [31:0]    csr_rdata, trap_pc;
    logic [31:0]    pc_plus4, wb_data, pc_next;

    assign imem_addr = pc;
    assign instr.raw = imem_rdata;
    assign pc_plus4  = pc + 32'd4;

    rv_decode u_decode (.instr(instr), .ctrl(ctrl), .imm(imm));

    rv_regfile u_regfile (
        .clk(clk),
        .rs1_addr(instr.r.rs1),
        .rs2_addr(instr.r.rs2),
        .rd_addr(instr.r.rd),
        .rd_data(wb_data),
        .we(ctrl.rd_we),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    assign alu_a = ctrl.a_sel ? pc : rs1_data;

    always_comb begin
        case (ctrl.b_sel)
            2'd0:    alu_b = rs2_data;
            2'd1:    alu_b = imm;
            default: alu_b = 32'h0;
        endcase
    end

    rv_alu u_alu (
        .a(alu_a), .b(alu_b), .op(ctrl.alu_op),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .br_type(ctrl.br_type),
        .result(alu_result), .br_taken(br_taken)
    );

    rv_csr u_csr (
        .clk(clk), .arst_n(arst_n), .instr(instr), .ctrl(ctrl), .pc(pc),
        .wdata(alu_result), .csr_rdata(csr_rdata), .trap_pc(trap_pc)
    );

    always_comb begin
        case (ctrl.wb_sel)
            2'd0:    wb_data = alu_result;
            2'd1:    wb_data = pc_plus4;   // link
            2'd2:    wb_data = dmem_rdata;
            default: wb_data = csr_rdata;  // old csr value
        endcase
    end

    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;
    assign dmem_req.re    = ctrl.mem_re & arst_n;
    assign dmem_req.we    = ctrl.mem_we & arst_n;

    always_comb begin
        if (ctrl.ecall || ctrl.mret)
            pc_next = trap_pc;
        else if (ctrl.jump || br_taken)
            pc_next = {alu_result[31:1], 1'b0};
        else
            pc_next = pc_plus4;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc <= `RV_RESET_PC;
        else
            pc <= pc_next;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
    input  logic rst_req,
    output logic clk,
    output logic arst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] left;
    logic       req;

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        left   = 2'd3;
        forever #4 clk = ~clk; // 8 ns period
    end

    always @(posedge clk) begin
        req = rst_req; // sampled at the edge
        #1;
        if (req)
            left = 2'd3;
        if (left != 2'd0) begin
            arst_n = 1'b0;
            left   = left - 2'd1;
        end else begin
            arst_n = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- testbench/rv_core_assertions.sv
`default_nettype none

module rv_core_assertions (
    input logic              clk,
    input logic              arst_n,
    input logic [31:0]       pc,
    input rv_pkg::dmem_req_t dmem_req
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned assert_fails = 0; // failed assertions so far

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else begin
            $error("pc not word aligned: %h", pc);
            assert_fails++;
        end

    no_read_and_write: assert property (@(posedge clk) !(dmem_req.re && dmem_req.we))
        else begin
            $error("data memory read and write in the same cycle");
            assert_fails++;
        end

    write_aligned: assert property (@(posedge clk)
        dmem_req.we |-> dmem_req.addr[1:0] == 2'b00)
        else begin
            $error("misaligned store address %h", dmem_req.addr);
            assert_fails++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !dmem_req.re && !dmem_req.we)
        else begin
            $error("memory request while in reset");
            assert_fails++;
        end

endmodule

bind rv_core rv_core_assertions u_assert (
    .clk(clk), .arst_n(arst_n), .pc(pc), .dmem_req(dmem_req)
);

`default_nettype wire

//--- testbench/rv_core_tb.sv
`default_nettype none

`include "rv_consts.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUDGET_CYCLES  = 300;
    localparam int TIMEOUT_CYCLES = 6 * BUDGET_CYCLES + 200;

    logic              clk, arst_n, rst_req;
    logic [31:0]       imem_addr, imem_rdata, dmem_rdata, pc;
    rv_pkg::dmem_req_t dmem_req;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] prog [256];
    int          prog_len;
    int          exp_idx [$];
    logic [31:0] exp_val [$];
    logic        sentinel_seen;
    int          errors;
    int          cycles;
    string       test_name;

    tb_clkgen clkgen_i (.rst_req(rst_req), .clk(clk), .arst_n(arst_n));

    rv_core rv_core_i (
        .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .pc(pc)
    );

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
            if (dmem_req.addr == 32'h3fc)
                sentinel_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] fill_word(input int i);
        return 32'h5a00_0000 ^ (i * 32'h0001_0104); // differs for every address
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    // RV32I integer op by funct3, alt = funct7[5]
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic pad_to(input int addr);
        while (prog_len * 4 < addr)
            emit(32'h0);
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] val);
        emit({val[31:12] + {19'b0, val[11]}, rd, `RV_OP_LUI});
        emit(enc_i(val[11:0], rd, 3'd0, rd, `RV_OP_IMM));
    endtask

    task automatic store(input logic [4:0] rs2, input logic [11:0] off, input logic [4:0] rs1);
        emit(enc_s(off, rs2, rs1));
    endtask

    task automatic expect_word(input int idx, input logic [31:0] val);
        exp_idx.push_back(idx);
        exp_val.push_back(val);
    endtask

    task automatic check(input string what, input logic [31:0] expected,
        input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    // reset, load, run to the sentinel store, then compare memory
    task automatic run_program(input string name);
        int n;
        test_name = name;
        store(5'd0, 12'h3fc, 5'd0);
        emit(enc_j(21'd0, 5'd0)); // halt loop
        @(posedge clk);
        #1 rst_req = 1'b1;
        wait (arst_n === 1'b0);
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog_len) ? prog[i] : 32'h0;
            dmem[i] = fill_word(i);
        end
        sentinel_seen = 1'b0;
        rst_req = 1'b0;
        wait (arst_n === 1'b1);
        check("reset pc", 32'h0, pc);
        n = 0;
        while (!sentinel_seen && n < BUDGET_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (!sentinel_seen) begin
            errors++;
            $display("%s: program did not reach its final store in %0d cycles",
                     name, BUDGET_CYCLES);
        end
        foreach (exp_idx[k])
            check($sformatf("word %0d", exp_idx[k]), exp_val[k], dmem[exp_idx[k]]);
        exp_idx.delete();
        exp_val.delete();
        prog_len = 0;
    endtask

    task automatic test_alu();
        logic [2:0]  f3r [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
        logic        altr [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
        logic [2:0]  f3i [9] = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
        logic [31:0] a, b;
        logic [11:0] imm;
        a = $urandom();
        b = $urandom();
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit(enc_r(altr[k] ? 7'h20 : 7'h00, 5'd2, 5'd1, f3r[k], 5'd3));
            store(5'd3, 12'(4 * k), 5'd0);
            expect_word(k, ref_alu(f3r[k], altr[k], a, b));
        end
        for (int k = 0; k < 9; k++) begin
            imm = 12'($urandom());
            if (f3i[k] == 3'd1 || f3i[k] == 3'd5)
                imm = {(k == 8) ? 7'h20 : 7'h00, imm[4:0]}; // shamt form
            emit(enc_i(imm, 5'd1, f3i[k], 5'd3, `RV_OP_IMM));
            store(5'd3, 12'(4 * (10 + k)), 5'd0);
            expect_word(10 + k, ref_alu(f3i[k], k == 8, a, {{20{imm[11]}}, imm}));
        end
        run_program("alu");
    endtask

    task automatic test_jumps();
        emit(enc_j(21'd8, 5'd1));                 // 0
        store(5'd0, 12'h040, 5'd0);               // 4, skipped
        store(5'd1, 12'h000, 5'd0);               // 8
        emit({20'h12345, 5'd2, `RV_OP_AUIPC});    // 12
        store(5'd2, 12'h004, 5'd0);
        emit({20'habcde, 5'd3, `RV_OP_LUI});      // 20
        store(5'd3, 12'h008, 5'd0);
        emit(enc_i(12'd44, 5'd0, 3'd0, 5'd4, `RV_OP_IMM));
        emit(enc_i(12'd0, 5'd4, 3'd0, 5'd5, `RV_OP_JALR)); // 32
        store(5'd0, 12'h044, 5'd0);               // 36, skipped
        store(5'd0, 12'h048, 5'd0);               // 40, skipped
        store(5'd5, 12'h00c, 5'd0);               // 44
        expect_word(0, 32'd4);
        expect_word(1, 32'd12 + 32'h1234_5000);
        expect_word(2, 32'habcd_e000);
        expect_word(3, 32'd36);
        for (int i = 16; i < 19; i++)
            expect_word(i, fill_word(i));
        run_program("jumps");
    endtask

    task automatic test_branches();
        logic [2:0]  kinds [6] = '{0, 1, 4, 5, 6, 7};
        logic [31:0] pa [3] = '{32'hffff_fffd, 32'd5, 32'd5};
        logic [31:0] pb [3] = '{32'd5, 32'd5, 32'hffff_fffd};
        int          taken, not_taken;
        taken = 0;
        not_taken = 0;
        emit(enc_i(12'd0, 5'd0, 3'd0, 5'd10, `RV_OP_IMM));
        emit(enc_i(12'd0, 5'd0, 3'd0, 5'd11, `RV_OP_IMM));
        foreach (kinds[k]) begin
            for (int p = 0; p < 3; p++) begin
                load_const(5'd1, pa[p]);
                load_const(5'd2, pb[p]);
                emit(enc_b(13'd12, 5'd2, 5'd1, kinds[k]));
                emit(enc_i(12'd1, 5'd10, 3'd0, 5'd10, `RV_OP_IMM)); // fall through
                emit(enc_j(21'd8, 5'd0));
                emit(enc_i(12'd1, 5'd11, 3'd0, 5'd11, `RV_OP_IMM)); // target
                if (ref_branch(kinds[k], pa[p], pb[p]))
                    taken++;
                else
                    not_taken++;
            end
        end
        store(5'd10, 12'h000, 5'd0);
        store(5'd11, 12'h004, 5'd0);
        expect_word(0, 32'(not_taken));
        expect_word(1, 32'(taken));
        run_program("branches");
    endtask

    task automatic test_memory();
        logic [11:0] offs [4] = '{12'hff8, 12'h000, 12'h004, 12'h014};
        logic [31:0] w;
        store(5'd0, 12'h300, 5'd0); // first word, decoded while in reset
        expect_word(192, 32'h0);
        load_const(5'd20, 32'h100);
        for (int k = 0; k < 4; k++) begin
            w = $urandom();
            load_const(5'd1, w);
            store(5'd1, offs[k], 5'd20);
            emit(enc_i(offs[k], 5'd20, 3'b010, 5'd2, `RV_OP_LOAD));
            store(5'd2, 12'(12'h200 + 4 * k), 5'd0);
            expect_word((32'h100 + {{20{offs[k][11]}}, offs[k]}) >> 2, w);
            expect_word(128 + k, w);
        end
        run_program("memory");
    endtask

    task automatic test_csr();
        emit(enc_i(12'h040, 5'd0, 3'd0, 5'd1, `RV_OP_IMM));
        emit(enc_i(`RV_CSR_MTVEC, 5'd1, 3'b001, 5'd2, `RV_OP_SYSTEM));
        store(5'd2, 12'h000, 5'd0);
        emit(enc_i(12'd3, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
        emit(enc_i(`RV_CSR_MTVEC, 5'd3, 3'b010, 5'd4, `RV_OP_SYSTEM));
        store(5'd4, 12'h004, 5'd0);
        emit(enc_i(`RV_CSR_MTVEC, 5'd0, 3'b010, 5'd5, `RV_OP_SYSTEM));
        store(5'd5, 12'h008, 5'd0);
        emit(enc_i(`RV_SYS_ECALL, 5'd0, 3'd0, 5'd0, `RV_OP_SYSTEM)); // at 32
        emit(enc_i(12'h077, 5'd0, 3'd0, 5'd9, `RV_OP_IMM));
        store(5'd9, 12'h00c, 5'd0);
        emit(enc_j(21'd48, 5'd0)); // over the handler to the final store
        pad_to(64);
        emit(enc_i(`RV_CSR_MEPC, 5'd0, 3'b010, 5'd6, `RV_OP_SYSTEM));
        store(5'd6, 12'h010, 5'd0);
        emit(enc_i(`RV_CSR_MCAUSE, 5'd0, 3'b010, 5'd7, `RV_OP_SYSTEM));
        store(5'd7, 12'h014, 5'd0);
        emit(enc_i(12'd4, 5'd6, 3'd0, 5'd6, `RV_OP_IMM));
        emit(enc_i(`RV_CSR_MEPC, 5'd6, 3'b001, 5'd0, `RV_OP_SYSTEM));
        emit(enc_i(`RV_SYS_MRET, 5'd0, 3'd0, 5'd0, `RV_OP_SYSTEM));
        expect_word(0, 32'h0);
        expect_word(1, 32'h40);
        expect_word(2, 32'h43);
        expect_word(3, 32'h77);
        expect_word(4, 32'd32);
        expect_word(5, 32'd11);
        run_program("csr");
    endtask

    task automatic test_x0();
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd0, `RV_OP_IMM));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd1, `RV_OP_IMM)); // skipped
        store(5'd0, 12'h000, 5'd0);
        expect_word(0, 32'h0);
        run_program("x0");
    endtask

    initial begin
        void'($urandom(32'hebfb_08f5));
        rst_req = 1'b0;
        errors = 0;
        cycles = 0;
        prog_len = 0;
        sentinel_seen = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0;
            dmem[i] = fill_word(i);
        end
        test_alu();
        test_jumps();
        test_branches();
        test_memory();
        test_csr();
        test_x0();
        errors += int'(rv_core_i.u_assert.assert_fails);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hdl/rv_pkg.sv
hdl/rv_decode.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_csr.sv
hdl/rv_core.sv
testbench/tb_clkgen.sv
testbench/rv_core_assertions.sv
testbench/rv_core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module rv_core_tb -o rv_core_sim

./obj_dir/rv_core_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Test failures found" sim.log || ! grep -q "All tests passed!" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
